/* Bender.yml */
package:
  name: mips_core

export_include_dirs:
  - include

sources:
  - files:
      - src/mips_pkg.sv
      - src/fetch_unit.sv
      - src/decoder.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/execute_stage.sv
      - src/writeback_stage.sv
      - src/cpu_top.sv
  - target: test
    files:
      - verif/tb_cpu.sv

/* flist.f */
+incdir+include
src/mips_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/execute_stage.sv
src/writeback_stage.sv
src/cpu_top.sv
verif/tb_cpu.sv

/* include/mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// datapath and address width
`define WORD_W 32

// architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// first fetch after reset
`define RESET_VECTOR 32'hbfc00000

// byte enables on the data sram
`define BE_W 4

`endif

/* src/alu.sv */
`timescale 1ns/10ps

module alu import mips_pkg::*; (
	input  alu_op_e op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    zero
);

	always_comb
	begin
		case (op)
			alu_add:  result = a + b;
			alu_sub:  result = a - b;
			alu_and:  result = a & b;
			alu_or:   result = a | b;
			alu_xor:  result = a ^ b;
			alu_nor:  result = ~(a | b);
			alu_slt:  result = word_t'($signed(a) < $signed(b));
			alu_sltu: result = word_t'(a < b);
			// shift amount from the low bits of a
			alu_sll:  result = b << a[4:0];
			alu_srl:  result = b >> a[4:0];
			// immediate into the upper half
			alu_lui:  result = {b[15:0], 16'h0000};
			default:  result = '0;
		endcase
	end

	// equal compare for beq/bne
	assign zero = (result == '0);

endmodule

/* src/cpu_top.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module cpu_top import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,

	output logic              inst_sram_en,
	output logic [`BE_W-1:0]  inst_sram_wen,
	output word_t             inst_sram_addr,
	output word_t             inst_sram_wdata,
	input  word_t             inst_sram_rdata,

	output logic              data_sram_en,
	output logic [`BE_W-1:0]  data_sram_wen,
	output word_t             data_sram_addr,
	output word_t             data_sram_wdata,
	input  word_t             data_sram_rdata,

	output word_t             debug_wb_pc,
	output logic [`BE_W-1:0]  debug_wb_rf_wen,
	output reg_addr_t         debug_wb_rf_wnum,
	output word_t             debug_wb_rf_wdata
);

	logic      redirect;
	word_t     target;
	word_t     id_pc;
	ctrl_t     id_ctrl;
	reg_addr_t raddr1;
	reg_addr_t raddr2;
	word_t     rdata1;
	word_t     rdata2;
	wb_t       wb;
	logic      ex_valid;
	word_t     ex_inst;
	word_t     ex_pc;
	ctrl_t     ex_ctrl;
	word_t     ex_result;

	// instruction sram is read only, fetch every cycle
	assign inst_sram_en    = 1'b1;
	assign inst_sram_wen   = '0;
	assign inst_sram_wdata = '0;

	fetch_unit u_fetch (
		.clk        (clk),
		.resetn     (resetn),
		.redirect   (redirect),
		.target     (target),
		.fetch_addr (inst_sram_addr),
		.id_pc      (id_pc)
	);

	// sram read data is the ID instruction
	decoder u_decoder (
		.inst (inst_sram_rdata),
		.ctrl (id_ctrl)
	);

	reg_file u_reg_file (
		.clk    (clk),
		.resetn (resetn),
		.raddr1 (raddr1),
		.raddr2 (raddr2),
		.rdata1 (rdata1),
		.rdata2 (rdata2),
		.wb     (wb)
	);

	execute_stage u_execute (
		.clk       (clk),
		.resetn    (resetn),
		.id_inst   (inst_sram_rdata),
		.id_pc     (id_pc),
		.id_ctrl   (id_ctrl),
		.wb        (wb),
		.rdata1    (rdata1),
		.rdata2    (rdata2),
		.raddr1    (raddr1),
		.raddr2    (raddr2),
		.redirect  (redirect),
		.target    (target),
		.mem_en    (data_sram_en),
		.mem_wen   (data_sram_wen),
		.mem_addr  (data_sram_addr),
		.mem_wdata (data_sram_wdata),
		.ex_valid  (ex_valid),
		.ex_inst   (ex_inst),
		.ex_pc     (ex_pc),
		.ex_ctrl   (ex_ctrl),
		.ex_result (ex_result)
	);

	writeback_stage u_writeback (
		.clk       (clk),
		.resetn    (resetn),
		.ex_valid  (ex_valid),
		.ex_inst   (ex_inst),
		.ex_pc     (ex_pc),
		.ex_ctrl   (ex_ctrl),
		.ex_result (ex_result),
		.mem_rdata (data_sram_rdata),
		.wb        (wb),
		.dbg_pc    (debug_wb_pc),
		.dbg_wen   (debug_wb_rf_wen),
		.dbg_wnum  (debug_wb_rf_wnum),
		.dbg_wdata (debug_wb_rf_wdata)
	);

endmodule

/* src/decoder.sv */
`timescale 1ns/10ps

module decoder import mips_pkg::*; (
	input  word_t inst,
	output ctrl_t ctrl
);

	opcode_e opcode;
	funct_e  funct;
	alu_op_e r_op;
	logic    r_alu;

	assign opcode = opcode_e'(inst[31:26]);
	assign funct  = funct_e'(inst[5:0]);

	// special functions that write rd, jr excluded
	assign r_alu = funct inside {fn_sll, fn_srl, fn_addu, fn_subu, fn_and, fn_or,
		fn_xor, fn_nor, fn_slt, fn_sltu};

	// alu op for r-type
	always_comb
	begin
		case (funct)
			fn_sll:  r_op = alu_sll;
			fn_srl:  r_op = alu_srl;
			fn_subu: r_op = alu_sub;
			fn_and:  r_op = alu_and;
			fn_or:   r_op = alu_or;
			fn_xor:  r_op = alu_xor;
			fn_nor:  r_op = alu_nor;
			fn_slt:  r_op = alu_slt;
			fn_sltu: r_op = alu_sltu;
			default: r_op = alu_add;
		endcase
	end

	always_comb
	begin
		// alu op; beq/bne compare through subtract and the zero flag
		case (opcode)
			op_special:     ctrl.alu_op = r_op;
			op_beq, op_bne: ctrl.alu_op = alu_sub;
			op_slti:        ctrl.alu_op = alu_slt;
			op_andi:        ctrl.alu_op = alu_and;
			op_ori:         ctrl.alu_op = alu_or;
			op_lui:         ctrl.alu_op = alu_lui;
			default:        ctrl.alu_op = alu_add;
		endcase
		// operand b source
		case (opcode)
			op_addiu, op_slti, op_lw, op_sw: ctrl.b_src = b_sext;
			op_andi, op_ori, op_lui:         ctrl.b_src = b_zext;
			default:                         ctrl.b_src = b_rt;
		endcase
		// branch kind
		case (opcode)
			op_special: ctrl.branch = (funct == fn_jr) ? br_jr : br_none;
			op_beq:     ctrl.branch = br_beq;
			op_bne:     ctrl.branch = br_bne;
			op_j:       ctrl.branch = br_j;
			default:    ctrl.branch = br_none;
		endcase
		// register write, unknown opcodes fall out as a nop
		case (opcode)
			op_special:                                  ctrl.reg_write = r_alu;
			op_addiu, op_slti, op_andi, op_ori, op_lui:  ctrl.reg_write = 1'b1;
			op_lw:                                       ctrl.reg_write = 1'b1;
			default:                                     ctrl.reg_write = 1'b0;
		endcase
		// sll/srl take shamt as operand a
		ctrl.shamt_a   = (opcode == op_special) && (funct == fn_sll || funct == fn_srl);
		// rd for r-type, rt otherwise
		ctrl.dest_rd   = (opcode == op_special);
		ctrl.mem_read  = (opcode == op_lw);
		ctrl.mem_write = (opcode == op_sw);
	end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module execute_stage import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  word_t             id_inst,
	input  word_t             id_pc,
	input  ctrl_t             id_ctrl,
	input  wb_t               wb,
	input  word_t             rdata1,
	input  word_t             rdata2,
	output reg_addr_t         raddr1,
	output reg_addr_t         raddr2,
	output logic              redirect,
	output word_t             target,
	output logic              mem_en,
	output logic [`BE_W-1:0]  mem_wen,
	output word_t             mem_addr,
	output word_t             mem_wdata,
	output logic              ex_valid,
	output word_t             ex_inst,
	output word_t             ex_pc,
	output ctrl_t             ex_ctrl,
	output word_t             ex_result
);

	word_t rs_val;
	word_t rt_val;
	word_t imm_sext;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic  alu_zero;
	logic  taken;

	// ID instruction is always valid once out of reset
	always_ff @(posedge clk)
	begin
		if (!resetn)
			ex_valid <= 1'b0;
		else
			ex_valid <= 1'b1;
	end

	// ID/EX payload
	always_ff @(posedge clk)
	begin
		ex_inst <= id_inst;
		ex_pc   <= id_pc;
		ex_ctrl <= id_ctrl;
	end

	// rs, rt
	assign raddr1 = ex_inst[25:21];
	assign raddr2 = ex_inst[20:16];

	// bypass from MEM, load data included
	// older writes are already in the register file
	assign rs_val = (wb.we && wb.waddr == raddr1) ? wb.wdata : rdata1;
	assign rt_val = (wb.we && wb.waddr == raddr2) ? wb.wdata : rdata2;

	assign imm_sext = {{16{ex_inst[15]}}, ex_inst[15:0]};

	// operand a is shamt for sll/srl
	assign alu_a = ex_ctrl.shamt_a ? word_t'(ex_inst[10:6]) : rs_val;

	always_comb
	begin
		case (ex_ctrl.b_src)
			b_sext:  alu_b = imm_sext;
			b_zext:  alu_b = {16'h0000, ex_inst[15:0]};
			default: alu_b = rt_val;
		endcase
	end

	alu u_alu (
		.op     (ex_ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// branch resolution
	// id_pc is the delay slot, i.e. branch pc plus four
	always_comb
	begin
		taken  = 1'b0;
		target = id_pc + {imm_sext[29:0], 2'b00};
		case (ex_ctrl.branch)
			br_beq: taken = alu_zero;
			br_bne: taken = !alu_zero;
			br_j:
			begin
				taken  = 1'b1;
				target = {id_pc[31:28], ex_inst[25:0], 2'b00};
			end
			br_jr:
			begin
				taken  = 1'b1;
				target = rs_val;
			end
			default: taken = 1'b0;
		endcase
	end

	assign redirect = ex_valid & taken;

	// data sram request, word accesses only
	assign mem_en    = ex_valid & (ex_ctrl.mem_read | ex_ctrl.mem_write);
	assign mem_wen   = {`BE_W{ex_valid & ex_ctrl.mem_write}};
	assign mem_addr  = alu_result;
	assign mem_wdata = rt_val;

	assign ex_result = alu_result;

	// base plus offset must stay word aligned, there are no byte lanes
	assert property (@(posedge clk) disable iff (!resetn) mem_en |-> mem_addr[1:0] == 2'b00)
		else $error("unaligned data access at %h", mem_addr);

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module fetch_unit import mips_pkg::*; (
	input  logic  clk,
	input  logic  resetn,
	input  logic  redirect,
	input  word_t target,
	output word_t fetch_addr,
	output word_t id_pc
);

	// next fetch address
	// a redirect from EX lands right after the delay slot now in ID
	always_comb
	begin
		if (!resetn)
			fetch_addr = `RESET_VECTOR;
		else if (redirect)
			fetch_addr = target;
		else
			fetch_addr = id_pc + 32'd4;
	end

	// sram returns the word one cycle later, so this is the pc of the ID instruction
	always_ff @(posedge clk)
	begin
		id_pc <= fetch_addr;
	end

	// jr targets come from a register, so alignment is up to the program
	assert property (@(posedge clk) disable iff (!resetn) fetch_addr[1:0] == 2'b00)
		else $error("fetch address %h not word aligned", fetch_addr);

endmodule

/* src/mips_pkg.sv */
`include "mips_params.svh"

package mips_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

	// primary opcodes, inst[31:26]
	typedef enum logic [5:0] {
		op_special = 6'h00,
		op_j       = 6'h02,
		op_beq     = 6'h04,
		op_bne     = 6'h05,
		op_addiu   = 6'h09,
		op_slti    = 6'h0a,
		op_andi    = 6'h0c,
		op_ori     = 6'h0d,
		op_lui     = 6'h0f,
		op_lw      = 6'h23,
		op_sw      = 6'h2b
	} opcode_e;

	// special function codes, inst[5:0]
	typedef enum logic [5:0] {
		fn_sll  = 6'h00,
		fn_srl  = 6'h02,
		fn_jr   = 6'h08,
		fn_addu = 6'h21,
		fn_subu = 6'h23,
		fn_and  = 6'h24,
		fn_or   = 6'h25,
		fn_xor  = 6'h26,
		fn_nor  = 6'h27,
		fn_slt  = 6'h2a,
		fn_sltu = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_lui
	} alu_op_e;

	// second alu operand
	typedef enum logic [1:0] {b_rt, b_sext, b_zext} b_src_e;

	typedef enum logic [2:0] {br_none, br_beq, br_bne, br_j, br_jr} branch_e;

	typedef struct packed {
		alu_op_e alu_op;
		b_src_e  b_src;
		branch_e branch;
		logic    shamt_a;
		logic    dest_rd;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
	} ctrl_t;

	// register write port, also the forwarding source
	typedef struct packed {
		logic      we;
		reg_addr_t waddr;
		word_t     wdata;
	} wb_t;

endpackage

/* src/reg_file.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module reg_file import mips_pkg::*; (
	input  logic      clk,
	input  logic      resetn,
	input  reg_addr_t raddr1,
	input  reg_addr_t raddr2,
	output word_t     rdata1,
	output word_t     rdata2,
	input  wb_t       wb
);

	word_t regs [`NUM_REGS];

	// r0 is never written, so it stays at its reset value of zero
	always_ff @(posedge clk)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb.we)
			regs[wb.waddr] <= wb.wdata;
	end

	// asynchronous reads
	assign rdata1 = regs[raddr1];
	assign rdata2 = regs[raddr2];

	// writeback filters out r0 before it gets here
	assert property (@(posedge clk) disable iff (!resetn) wb.we |-> wb.waddr != '0)
		else $error("write enable with destination r0");

endmodule

/* src/writeback_stage.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module writeback_stage import mips_pkg::*; (
	input  logic              clk,
	input  logic              resetn,
	input  logic              ex_valid,
	input  word_t             ex_inst,
	input  word_t             ex_pc,
	input  ctrl_t             ex_ctrl,
	input  word_t             ex_result,
	input  word_t             mem_rdata,
	output wb_t               wb,
	output word_t             dbg_pc,
	output logic [`BE_W-1:0]  dbg_wen,
	output reg_addr_t         dbg_wnum,
	output word_t             dbg_wdata
);

	logic      mem_valid;
	word_t     mem_inst;
	word_t     mem_pc;
	ctrl_t     mem_ctrl;
	word_t     mem_result;
	reg_addr_t waddr;

	always_ff @(posedge clk)
	begin
		if (!resetn)
			mem_valid <= 1'b0;
		else
			mem_valid <= ex_valid;
	end

	// EX/MEM payload
	always_ff @(posedge clk)
	begin
		mem_inst   <= ex_inst;
		mem_pc     <= ex_pc;
		mem_ctrl   <= ex_ctrl;
		mem_result <= ex_result;
	end

	// rd or rt
	assign waddr = mem_ctrl.dest_rd ? mem_inst[15:11] : mem_inst[20:16];

	// r0 dropped here once for the regfile and the bypass
	assign wb.we    = mem_valid & mem_ctrl.reg_write & (waddr != '0);
	assign wb.waddr = waddr;
	// load data arrives this cycle
	assign wb.wdata = mem_ctrl.mem_read ? mem_rdata : mem_result;

	// trace, one cycle behind the regfile write
	always_ff @(posedge clk)
	begin
		if (!resetn)
			dbg_wen <= '0;
		else
			dbg_wen <= {`BE_W{wb.we}};
	end

	always_ff @(posedge clk)
	begin
		dbg_pc    <= mem_pc;
		dbg_wnum  <= wb.waddr;
		dbg_wdata <= wb.wdata;
	end

endmodule

/* verif/tb_cpu.sv */
`timescale 1ns/10ps
`include "mips_params.svh"

module tb_cpu import mips_pkg::*; ();

	localparam int RESET_CYCLES = 4;
	localparam int IMEM_WORDS = 256;
	localparam int RAND_COUNT = 200;
	// slot of the final j-to-self, its nop delay slot follows
	localparam int END_SLOT = RAND_COUNT + 1;
	localparam int PROG_WORDS = END_SLOT + 2;
	localparam int PIPE_DEPTH = 4;
	localparam int MARGIN = 32;
	// reset plus program plus pipeline depth and a margin
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + PROG_WORDS + PIPE_DEPTH + MARGIN;
	localparam int DRAIN_CYCLES = 2 * PIPE_DEPTH;
	localparam int STEP_LIMIT = 4 * PROG_WORDS;
	localparam word_t DATA_BASE = 32'h1000_0000;
	localparam word_t END_ADDR = `RESET_VECTOR + 32'(END_SLOT * 4);

	typedef enum logic [1:0] {ev_none, ev_reg, ev_store} ev_kind_e;

	// one expected architectural effect
	typedef struct packed {
		ev_kind_e  kind;
		word_t     pc;
		reg_addr_t wnum;
		word_t     data;
		word_t     addr;
	} ref_item_t;

	logic              clk;
	logic              resetn;
	logic              inst_sram_en;
	logic [`BE_W-1:0]  inst_sram_wen;
	word_t             inst_sram_addr;
	word_t             inst_sram_wdata;
	word_t             inst_sram_rdata;
	logic              data_sram_en;
	logic [`BE_W-1:0]  data_sram_wen;
	word_t             data_sram_addr;
	word_t             data_sram_wdata;
	word_t             data_sram_rdata;
	word_t             debug_wb_pc;
	logic [`BE_W-1:0]  debug_wb_rf_wen;
	reg_addr_t         debug_wb_rf_wnum;
	word_t             debug_wb_rf_wdata;

	// instruction rom indexed from the reset vector and the data ram
	word_t imem [IMEM_WORDS];
	logic  is_target [IMEM_WORDS];
	word_t dmem [256];
	word_t i_addr_q = `RESET_VECTOR;
	logic [7:0] d_idx_q = '0;

	// architectural model state
	word_t ref_pc;
	word_t ref_npc;
	word_t ref_regs [`NUM_REGS];
	word_t ref_dmem [256];

	ref_item_t wb_q [$];
	ref_item_t st_q [$];
	ref_item_t next_wb;
	ref_item_t next_st;
	int cycle_count = 0;

	cpu_top DUT (
		.clk               (clk),
		.resetn            (resetn),
		.inst_sram_en      (inst_sram_en),
		.inst_sram_wen     (inst_sram_wen),
		.inst_sram_addr    (inst_sram_addr),
		.inst_sram_wdata   (inst_sram_wdata),
		.inst_sram_rdata   (inst_sram_rdata),
		.data_sram_en      (data_sram_en),
		.data_sram_wen     (data_sram_wen),
		.data_sram_addr    (data_sram_addr),
		.data_sram_wdata   (data_sram_wdata),
		.data_sram_rdata   (data_sram_rdata),
		.debug_wb_pc       (debug_wb_pc),
		.debug_wb_rf_wen   (debug_wb_rf_wen),
		.debug_wb_rf_wnum  (debug_wb_rf_wnum),
		.debug_wb_rf_wdata (debug_wb_rf_wdata)
	);

	always #4 clk = ~clk;

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_wb(input word_t exp_pc, input word_t got_pc,
		input reg_addr_t exp_num, input reg_addr_t got_num,
		input word_t exp_data, input word_t got_data);
		if (got_pc !== exp_pc || got_num !== exp_num || got_data !== exp_data)
			fail_now($sformatf("[ERROR] %0t: write expected pc %h r%0d=%h, got pc %h r%0d=%h",
				$time, exp_pc, exp_num, exp_data, got_pc, got_num, got_data));
	endtask

	task automatic check_store(input word_t exp_addr, input word_t got_addr,
		input word_t exp_data, input word_t got_data);
		if (got_addr !== exp_addr || got_data !== exp_data)
			fail_now($sformatf("[ERROR] %0t: store expected [%h]=%h, got [%h]=%h",
				$time, exp_addr, exp_data, got_addr, got_data));
	endtask

	// instruction encoders
	function automatic word_t rtype_word(input funct_e fn, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] sa);
		return {op_special, rs, rt, rd, sa, fn};
	endfunction

	function automatic word_t itype_word(input opcode_e op, input reg_addr_t rs,
		input reg_addr_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t jump_word(input word_t target);
		return {op_j, target[27:2]};
	endfunction

	function automatic word_t slot_addr(input int slot);
		return `RESET_VECTOR + word_t'(slot) * 4;
	endfunction

	// mostly a small register set so hazards come up often
	function automatic reg_addr_t rand_reg();
		if ($urandom_range(0, 3) == 0)
			return reg_addr_t'($urandom_range(0, 31));
		else
			return reg_addr_t'($urandom_range(0, 7));
	endfunction

	// r28 stays the data pointer
	function automatic reg_addr_t rand_dest();
		reg_addr_t r;
		do
			r = rand_reg();
		while (r == 5'd28);
		return r;
	endfunction

	function automatic logic [15:0] rand_imm();
		if ($urandom_range(0, 1) == 1)
			return 16'($urandom);
		else
			return 16'($urandom_range(0, 31));
	endfunction

	function automatic funct_e pick_funct();
		case ($urandom_range(0, 9))
			0: return fn_sll;
			1: return fn_srl;
			2: return fn_addu;
			3: return fn_subu;
			4: return fn_and;
			5: return fn_or;
			6: return fn_xor;
			7: return fn_nor;
			8: return fn_slt;
			default: return fn_sltu;
		endcase
	endfunction

	function automatic opcode_e pick_imm_op();
		case ($urandom_range(0, 4))
			0: return op_addiu;
			1: return op_slti;
			2: return op_andi;
			3: return op_ori;
			default: return op_lui;
		endcase
	endfunction

	// fill value tied to the full byte address
	function automatic word_t mem_fill(input int idx);
		return (DATA_BASE + word_t'(idx) * 4) ^ 32'ha5a5_0000;
	endfunction

	function automatic word_t fetch_word(input word_t addr);
		word_t offs;
		offs = addr - `RESET_VECTOR;
		if (offs[31:2] < IMEM_WORDS)
			return imem[offs[31:2]];
		else
			return '0;
	endfunction

	task automatic build_program();
		int i;
		int kind;
		int off;
		int tgt;
		logic prev_ctrl;
		reg_addr_t rs;
		reg_addr_t rt;
		funct_e fn;
		word_t addr;
		for (i = 0; i < IMEM_WORDS; i++)
		begin
			imem[i] = '0;
			is_target[i] = 1'b0;
		end
		// prologue points r28 at the data region
		imem[0] = itype_word(op_lui, 5'd0, 5'd28, DATA_BASE[31:16]);
		prev_ctrl = 1'b0;
		i = 1;
		while (i <= RAND_COUNT)
		begin
			kind = $urandom_range(0, 17);
			// no control flow in a delay slot or right before the end loop
			if (kind >= 14 && (prev_ctrl || i >= RAND_COUNT))
				kind = 0;
			// no branch may land on the ori or jr of a lui/ori/jr group
			if (kind == 17 && (i + 2 >= RAND_COUNT || is_target[i + 1] || is_target[i + 2]))
				kind = 0;
			prev_ctrl = (kind >= 14);
			rs = rand_reg();
			rt = rand_reg();
			if (kind < 8)
			begin
				fn = pick_funct();
				if (fn == fn_sll || fn == fn_srl)
					imem[i] = rtype_word(fn, 5'd0, rt, rand_dest(), 5'($urandom_range(0, 31)));
				else
					imem[i] = rtype_word(fn, rs, rt, rand_dest(), 5'd0);
			end
			else if (kind < 12)
				imem[i] = itype_word(pick_imm_op(), rs, rand_dest(), rand_imm());
			else if (kind == 12)
				imem[i] = itype_word(op_lw, 5'd28, rand_dest(), 16'($urandom_range(0, 15) * 4));
			else if (kind == 13)
				imem[i] = itype_word(op_sw, 5'd28, rt, 16'($urandom_range(0, 15) * 4));
			else if (kind < 17)
			begin
				// forward only by up to seven words past the delay slot
				off = $urandom_range(1, 7);
				if (i + 1 + off > END_SLOT)
					off = END_SLOT - i - 1;
				tgt = i + 1 + off;
				is_target[tgt] = 1'b1;
				// equal operands half the time so beq gets taken
				if ($urandom_range(0, 1) == 1)
					rt = rs;
				if (kind == 14)
					imem[i] = itype_word(op_beq, rs, rt, 16'(off));
				else if (kind == 15)
					imem[i] = itype_word(op_bne, rs, rt, 16'(off));
				else
					imem[i] = jump_word(slot_addr(tgt));
			end
			else
			begin
				off = $urandom_range(1, 7);
				if (i + 3 + off > END_SLOT)
					off = END_SLOT - i - 3;
				tgt = i + 3 + off;
				is_target[tgt] = 1'b1;
				addr = slot_addr(tgt);
				rt = rand_dest();
				if (rt == 5'd0)
					rt = 5'd1;
				imem[i] = itype_word(op_lui, 5'd0, rt, addr[31:16]);
				imem[i + 1] = itype_word(op_ori, rt, rt, addr[15:0]);
				imem[i + 2] = rtype_word(fn_jr, rt, 5'd0, 5'd0, 5'd0);
				i = i + 2;
			end
			i++;
		end
		// final loop with a nop delay slot
		imem[END_SLOT] = jump_word(END_ADDR);
		imem[END_SLOT + 1] = '0;
	endtask

	// steps the architectural model by one instruction with pc/npc for the delay slot
	function automatic ref_item_t exec_ref();
		word_t inst;
		word_t rs_v;
		word_t rt_v;
		word_t sext;
		word_t zext;
		word_t ea;
		word_t res;
		word_t nnpc;
		reg_addr_t dst;
		logic wr;
		ref_item_t item;
		inst = fetch_word(ref_pc);
		rs_v = ref_regs[inst[25:21]];
		rt_v = ref_regs[inst[20:16]];
		sext = {{16{inst[15]}}, inst[15:0]};
		zext = {16'h0000, inst[15:0]};
		ea = rs_v + sext;
		res = '0;
		dst = inst[20:16];
		wr = 1'b0;
		nnpc = ref_npc + 4;
		item = '0;
		item.pc = ref_pc;
		case (opcode_e'(inst[31:26]))
			op_special:
			begin
				dst = inst[15:11];
				wr = 1'b1;
				case (funct_e'(inst[5:0]))
					fn_sll:  res = rt_v << inst[10:6];
					fn_srl:  res = rt_v >> inst[10:6];
					fn_addu: res = rs_v + rt_v;
					fn_subu: res = rs_v - rt_v;
					fn_and:  res = rs_v & rt_v;
					fn_or:   res = rs_v | rt_v;
					fn_xor:  res = rs_v ^ rt_v;
					fn_nor:  res = ~(rs_v | rt_v);
					fn_slt:  res = ($signed(rs_v) < $signed(rt_v)) ? 32'd1 : 32'd0;
					fn_sltu: res = (rs_v < rt_v) ? 32'd1 : 32'd0;
					fn_jr:
					begin
						wr = 1'b0;
						nnpc = rs_v;
					end
					default: wr = 1'b0;
				endcase
			end
			op_addiu:
			begin
				res = ea;
				wr = 1'b1;
			end
			op_slti:
			begin
				res = ($signed(rs_v) < $signed(sext)) ? 32'd1 : 32'd0;
				wr = 1'b1;
			end
			op_andi:
			begin
				res = rs_v & zext;
				wr = 1'b1;
			end
			op_ori:
			begin
				res = rs_v | zext;
				wr = 1'b1;
			end
			op_lui:
			begin
				res = {inst[15:0], 16'h0000};
				wr = 1'b1;
			end
			op_lw:
			begin
				res = ref_dmem[ea[9:2]];
				wr = 1'b1;
			end
			op_sw:
			begin
				ref_dmem[ea[9:2]] = rt_v;
				item.kind = ev_store;
				item.addr = ea;
				item.data = rt_v;
			end
			// ref_npc is the delay slot address
			op_beq:
			begin
				if (rs_v == rt_v)
					nnpc = ref_npc + {sext[29:0], 2'b00};
			end
			op_bne:
			begin
				if (rs_v != rt_v)
					nnpc = ref_npc + {sext[29:0], 2'b00};
			end
			op_j:    nnpc = {ref_npc[31:28], inst[25:0], 2'b00};
			default: wr = 1'b0;
		endcase
		if (wr && dst != 5'd0)
		begin
			ref_regs[dst] = res;
			item.kind = ev_reg;
			item.wnum = dst;
			item.data = res;
		end
		ref_pc = ref_npc;
		ref_npc = nnpc;
		return item;
	endfunction

	// sram models take the request at the rising edge and drive data at the falling edge
	always @(posedge clk)
	begin
		if (inst_sram_en === 1'b1)
			i_addr_q <= inst_sram_addr;
		if (data_sram_en === 1'b1)
		begin
			d_idx_q <= data_sram_addr[9:2];
			for (int b = 0; b < `BE_W; b++)
				if (data_sram_wen[b] === 1'b1)
					dmem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
		end
	end

	always @(negedge clk)
	begin
		inst_sram_rdata = fetch_word(i_addr_q);
		data_sram_rdata = dmem[d_idx_q];
	end

	// compare trace and stores against the expected streams
	always @(posedge clk)
	begin
		// instruction sram is read only and always enabled
		if (inst_sram_en !== 1'b1 || inst_sram_wen !== '0 || inst_sram_wdata !== '0)
			fail_now($sformatf("[ERROR] %0t: instruction sram en %b wen %b wdata %h", $time,
				inst_sram_en, inst_sram_wen, inst_sram_wdata));
		else if (resetn === 1'b0)
		begin
			if (inst_sram_addr !== `RESET_VECTOR)
				fail_now($sformatf("[ERROR] %0t: fetch at %h during reset", $time, inst_sram_addr));
			// valid bits are clear after the first edge in reset
			else if (cycle_count > 0 && (data_sram_en !== 1'b0 || data_sram_wen !== '0
				|| debug_wb_rf_wen !== '0))
				fail_now($sformatf("[ERROR] %0t: data en %b wen %b trace wen %b in reset",
					$time, data_sram_en, data_sram_wen, debug_wb_rf_wen));
		end
		else
		begin
			if (data_sram_wen !== '0)
			begin
				if (data_sram_wen !== '1 || data_sram_en !== 1'b1)
					fail_now($sformatf("[ERROR] %0t: store enables %b with en %b", $time,
						data_sram_wen, data_sram_en));
				else if (st_q.size() == 0)
					fail_now($sformatf("[ERROR] %0t: unexpected store to %h", $time,
						data_sram_addr));
				else
				begin
					next_st = st_q.pop_front();
					check_store(next_st.addr, data_sram_addr, next_st.data, data_sram_wdata);
				end
			end
			if (debug_wb_rf_wen !== '0)
			begin
				if (debug_wb_rf_wen !== '1)
					fail_now($sformatf("[ERROR] %0t: trace write enables %b", $time,
						debug_wb_rf_wen));
				else if (debug_wb_rf_wnum == 5'd0)
					fail_now($sformatf("[ERROR] %0t: trace shows a write to r0", $time));
				else if (wb_q.size() == 0)
					fail_now($sformatf("[ERROR] %0t: unexpected write to r%0d", $time,
						debug_wb_rf_wnum));
				else
				begin
					next_wb = wb_q.pop_front();
					check_wb(next_wb.pc, debug_wb_pc, next_wb.wnum, debug_wb_rf_wnum,
						next_wb.data, debug_wb_rf_wdata);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_now("timeout: the core did not finish the program in time");
	end

	initial
	begin
		int steps;
		ref_item_t item;
		clk = 1'b0;
		resetn = 1'b0;
		inst_sram_rdata = '0;
		data_sram_rdata = '0;
		void'($urandom(32'h4fea));
		build_program();
		for (int k = 0; k < 256; k++)
		begin
			dmem[k] = mem_fill(k);
			ref_dmem[k] = mem_fill(k);
		end
		for (int k = 0; k < `NUM_REGS; k++)
			ref_regs[k] = '0;
		// run the model to the final loop and collect what the core must show
		ref_pc = `RESET_VECTOR;
		ref_npc = `RESET_VECTOR + 4;
		steps = 0;
		while (ref_pc != END_ADDR && steps < STEP_LIMIT)
		begin
			item = exec_ref();
			if (item.kind == ev_reg)
				wb_q.push_back(item);
			else if (item.kind == ev_store)
				st_q.push_back(item);
			steps++;
		end
		if (ref_pc != END_ADDR)
			fail_now("the reference model never reached the final loop");
		repeat (RESET_CYCLES) @(negedge clk);
		resetn = 1'b1;
		while (wb_q.size() != 0 || st_q.size() != 0)
			@(negedge clk);
		// a few more cycles to catch stray writes
		repeat (DRAIN_CYCLES) @(negedge clk);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule
